/* src.f */
+incdir+src
src/riscvPkg.sv
src/instrDecode.sv
src/aluUnit.sv
src/registerFile.sv
src/memAlign.sv
src/controlFsm.sv
src/datapathUnit.sv
src/riscvCore.sv
test/tbMemory.sv
test/tb_riscvCore.sv

/* src/aluUnit.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module aluUnit import riscvPkg::*; (
  input  logic [`XLEN-1:0] srcA,
  input  logic [`XLEN-1:0] srcB,
  input  aluOp_e           aluOp,
  output logic [`XLEN-1:0] result,
  output aluFlags_t        flags
);

  logic [4:0] shamt;

  assign shamt = srcB[4:0];

  // Comparison flags independent of aluOp
  assign flags.zero = (srcA == srcB);
  assign flags.lt   = ($signed(srcA) < $signed(srcB));
  assign flags.ltu  = (srcA < srcB);

  always_comb begin
    case (aluOp)
      aluAdd: result = srcA + srcB;
      aluSub: result = srcA - srcB;
      aluSll: result = srcA << shamt;
      aluSlt: result = {{(`XLEN-1){1'b0}}, flags.lt};
      aluSltu: result = {{(`XLEN-1){1'b0}}, flags.ltu};
      aluXor: result = srcA ^ srcB;
      aluSrl: result = srcA >> shamt;
      aluSra: result = $unsigned($signed(srcA) >>> shamt);
      aluOr: result = srcA | srcB;
      aluAnd: result = srcA & srcB;
      default: result = srcB;             // LUI
    endcase
  end

endmodule

/* src/controlFsm.sv */
`timescale 1ns/100ps

module controlFsm import riscvPkg::*; (
  input  logic          clk,
  input  logic          rstN,
  input  decodedInstr_t instr,
  input  aluFlags_t     flags,
  output ctrlSignals_t  ctrl,
  output logic          halted
);

  fsmState_e state;
  fsmState_e nextState;
  logic      taken;

  function automatic aluOp_e aluDecode(input logic [2:0] f3, input logic f7b5,
                                       input logic isReg);
    case (f3)
      3'b000: return (isReg && f7b5) ? aluSub : aluAdd;
      3'b001: return aluSll;
      3'b010: return aluSlt;
      3'b011: return aluSltu;
      3'b100: return aluXor;
      3'b101: return f7b5 ? aluSra : aluSrl;
      3'b110: return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= stFetch;
    else state <= nextState;
  end

  // Branch condition from funct3
  always_comb begin
    case (instr.funct3)
      3'b000: taken = flags.zero;
      3'b001: taken = !flags.zero;
      3'b100: taken = flags.lt;
      3'b101: taken = !flags.lt;
      3'b110: taken = flags.ltu;
      3'b111: taken = !flags.ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    nextState          = state;
    ctrl               = '0;
    ctrl.srcASel       = srcAOldPc;      // oldPc + imm unless overridden
    ctrl.srcBSel       = srcBImm;
    ctrl.aluOp         = aluAdd;
    ctrl.resultSel     = resAluOut;
    ctrl.accessSize    = instr.funct3[1:0];
    ctrl.unsignedLoad  = instr.funct3[2];

    case (state)
      stFetch: begin
        ctrl.irWrite   = 1'b1;
        ctrl.pcWrite   = 1'b1;
        ctrl.srcASel   = srcAPc;
        ctrl.srcBSel   = srcBFour;
        ctrl.resultSel = resAluResult;
        nextState      = stDecode;
      end
      stDecode: begin
        // ALU output register now holds the branch or JAL target
        case (instr.opcode)
          opLoad, opStore: nextState = stMemAddr;
          opReg: nextState = stExecR;
          opImm, opLui, opAuipc: nextState = stExecI;
          opBranch: nextState = stBranch;
          opJal: nextState = stJal;
          opJalr: nextState = stJalr;
          opSystem: nextState = (instr.imm == 32'd1) ? stHalt : stFetch;
          default: nextState = stFetch;  // Unsupported opcode acts as NOP
        endcase
      end
      stMemAddr: begin
        ctrl.srcASel = srcARegA;
        nextState    = (instr.opcode == opStore) ? stMemWrite : stMemRead;
      end
      stMemRead: begin
        ctrl.adrSrc = 1'b1;
        nextState   = stMemWb;
      end
      stMemWb: begin
        ctrl.resultSel = resData;
        ctrl.regWrite  = 1'b1;
        nextState      = stFetch;
      end
      stMemWrite: begin
        ctrl.adrSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        nextState     = stFetch;
      end
      stExecR: begin
        ctrl.srcASel = srcARegA;
        ctrl.srcBSel = srcBRegB;
        ctrl.aluOp   = aluDecode(instr.funct3, instr.funct7b5, 1'b1);
        nextState    = stAluWb;
      end
      stExecI: begin
        if (instr.opcode == opLui) begin
          ctrl.aluOp = aluPassB;
        end else if (instr.opcode == opImm) begin
          ctrl.srcASel = srcARegA;
          ctrl.aluOp   = aluDecode(instr.funct3, instr.funct7b5, 1'b0);
        end
        nextState = stAluWb;
      end
      stAluWb: begin
        ctrl.regWrite = 1'b1;
        if (instr.opcode == opJal || instr.opcode == opJalr) begin
          ctrl.srcBSel   = srcBFour;       // Link is oldPc + 4
          ctrl.resultSel = resAluResult;
        end
        nextState = stFetch;
      end
      stBranch: begin
        ctrl.srcASel = srcARegA;
        ctrl.srcBSel = srcBRegB;
        ctrl.aluOp   = aluSub;
        ctrl.pcWrite = taken;
        nextState    = stFetch;
      end
      stJal: begin
        ctrl.pcWrite = 1'b1;
        nextState    = stAluWb;
      end
      stJalr: begin
        ctrl.srcASel   = srcARegA;
        ctrl.resultSel = resAluResult;
        ctrl.pcWrite   = 1'b1;
        nextState      = stAluWb;
      end
      default: nextState = stHalt;      // stHalt is terminal
    endcase
  end

  assign halted = (state == stHalt);

  assert property (@(posedge clk) disable iff (!rstN)
    ctrl.memWrite |-> (state == stMemWrite) ##1 !ctrl.memWrite)
    else $error("memWrite outside the store cycle or longer than one cycle");

  assert property (@(posedge clk) disable iff (!rstN)
    ctrl.irWrite |-> (state == stFetch) ##1 (state == stDecode))
    else $error("irWrite outside fetch");

  assert property (@(posedge clk) disable iff (!rstN)
    (state == stHalt) |=> (state == stHalt))
    else $error("Left the halt state");

endmodule

/* src/datapathUnit.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module datapathUnit import riscvPkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  ctrlSignals_t     ctrl,
  output decodedInstr_t    fields,
  output aluFlags_t        flags,
  output logic [`XLEN-1:0] memAddr,
  output logic [`XLEN-1:0] memWdata,
  output logic [3:0]       memWstrb,
  input  logic [`XLEN-1:0] memRdata,
  output logic [`XLEN-1:0] progCounter
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] oldPc;
  logic [`XLEN-1:0] instrReg;
  logic [`XLEN-1:0] regA;
  logic [`XLEN-1:0] regB;
  logic [`XLEN-1:0] aluOut;
  logic [`XLEN-1:0] dataReg;
  logic [`XLEN-1:0] rd1;
  logic [`XLEN-1:0] rd2;
  logic [`XLEN-1:0] srcA;
  logic [`XLEN-1:0] srcB;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] result;
  logic [`XLEN-1:0] loadData;
  logic [3:0]       wmask;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc       <= `RESET_ADDR;
      oldPc    <= `RESET_ADDR;
      instrReg <= `NOP_INSTR;
    end else begin
      if (ctrl.pcWrite) pc <= {result[`XLEN-1:1], 1'b0};  // JALR clears bit 0
      if (ctrl.irWrite) begin
        instrReg <= memRdata;
        oldPc    <= pc;
      end
    end
  end

  // Captured every cycle and used by the next state
  always_ff @(posedge clk) begin
    regA    <= rd1;
    regB    <= rd2;
    aluOut  <= aluResult;
    dataReg <= loadData;
  end

  always_comb begin
    case (ctrl.srcASel)
      srcAPc: srcA = pc;
      srcAOldPc: srcA = oldPc;
      default: srcA = regA;
    endcase
    case (ctrl.srcBSel)
      srcBRegB: srcB = regB;
      srcBImm: srcB = fields.imm;
      default: srcB = `XLEN'd4;
    endcase
    case (ctrl.resultSel)
      resAluOut: result = aluOut;
      resData: result = dataReg;
      default: result = aluResult;
    endcase
  end

  instrDecode uDecode (.instr(instrReg), .fields(fields));

  registerFile uRegs (
    .clk(clk), .we(ctrl.regWrite), .rs1(fields.rs1), .rs2(fields.rs2),
    .rd(fields.rd), .wd(result), .rd1(rd1), .rd2(rd2)
  );

  aluUnit uAlu (
    .srcA(srcA), .srcB(srcB), .aluOp(ctrl.aluOp), .result(aluResult), .flags(flags)
  );

  memAlign uAlign (
    .addrLow(memAddr[1:0]), .size(ctrl.accessSize), .unsignedLoad(ctrl.unsignedLoad),
    .storeData(regB), .rdata(memRdata), .wdata(memWdata), .wmask(wmask),
    .loadData(loadData)
  );

  assign memAddr     = ctrl.adrSrc ? result : pc;
  assign memWstrb    = wmask & {4{ctrl.memWrite}};   // Strobe only in the store cycle
  assign progCounter = oldPc;

endmodule

/* src/instrDecode.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module instrDecode import riscvPkg::*; (
  input  logic [`XLEN-1:0] instr,
  output decodedInstr_t    fields
);

  opcode_e          opcode;
  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;

  assign opcode = opcode_e'(instr[6:0]);

  // Sign bit is always instr[31]
  assign immI = {{21{instr[31]}}, instr[30:20]};
  assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    fields.opcode   = opcode;
    fields.funct3   = instr[14:12];
    fields.funct7b5 = instr[30];      // SUB and SRA select
    fields.rs1      = instr[19:15];
    fields.rs2      = instr[24:20];
    fields.rd       = instr[11:7];

    // Format follows from the opcode
    case (opcode)
      opStore: fields.imm = immS;
      opBranch: fields.imm = immB;
      opLui,
      opAuipc: fields.imm = immU;
      opJal: fields.imm = immJ;
      default: fields.imm = immI;     // Loads, OP-IMM, JALR, SYSTEM
    endcase
  end

endmodule

/* src/memAlign.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module memAlign (
  input  logic [1:0]       addrLow,
  input  logic [1:0]       size,          // 0 byte, 1 half, 2 word
  input  logic             unsignedLoad,
  input  logic [`XLEN-1:0] storeData,
  input  logic [`XLEN-1:0] rdata,
  output logic [`XLEN-1:0] wdata,
  output logic [3:0]       wmask,
  output logic [`XLEN-1:0] loadData
);

  logic [`XLEN-1:0] shifted;

  // Store lanes
  always_comb begin
    case (size)
      2'b00: begin
        wdata = {4{storeData[7:0]}};
        wmask = 4'b0001 << addrLow;
      end
      2'b01: begin
        wdata = {2{storeData[15:0]}};
        wmask = addrLow[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = storeData;
        wmask = 4'b1111;
      end
    endcase
  end

  // Addressed byte or half moved to bit 0
  assign shifted = rdata >> {addrLow, 3'b000};

  always_comb begin
    case (size)
      2'b00: loadData = {{24{!unsignedLoad && shifted[7]}}, shifted[7:0]};
      2'b01: loadData = {{16{!unsignedLoad && shifted[15]}}, shifted[15:0]};
      default: loadData = rdata;
    endcase
  end

endmodule

/* src/registerFile.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module registerFile #(
  parameter int AddrW = $clog2(`REG_COUNT)
) (
  input  logic             clk,
  input  logic             we,
  input  logic [AddrW-1:0] rs1,
  input  logic [AddrW-1:0] rs2,
  input  logic [AddrW-1:0] rd,
  input  logic [`XLEN-1:0] wd,
  output logic [`XLEN-1:0] rd1,
  output logic [`XLEN-1:0] rd2
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (we && rd != '0) regs[rd] <= wd;   // x0 stays unwritten
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

  assert property (@(posedge clk) (rs1 == '0) |-> (rd1 == '0))
    else $error("x0 read as nonzero");

endmodule

/* src/riscvCore.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module riscvCore import riscvPkg::*; (
  input  logic             clk,
  input  logic             rstN,
  output logic [`XLEN-1:0] memAddr,
  output logic [`XLEN-1:0] memWdata,
  output logic [3:0]       memWstrb,
  input  logic [`XLEN-1:0] memRdata,
  output logic [`XLEN-1:0] progCounter,
  output logic             halted
);

  ctrlSignals_t  ctrl;
  decodedInstr_t fields;
  aluFlags_t     flags;

  controlFsm uControl (
    .clk(clk), .rstN(rstN), .instr(fields), .flags(flags), .ctrl(ctrl), .halted(halted)
  );

  // Unified port serves fetch and data access
  datapathUnit uDatapath (
    .clk(clk), .rstN(rstN), .ctrl(ctrl), .fields(fields), .flags(flags),
    .memAddr(memAddr), .memWdata(memWdata), .memWstrb(memWstrb),
    .memRdata(memRdata), .progCounter(progCounter)
  );

endmodule

/* src/riscvPkg.sv */
`include "riscv_macros.svh"

package riscvPkg;

  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    stFetch, stDecode, stMemAddr, stMemRead, stMemWb, stMemWrite, stExecR,
    stExecI, stAluWb, stBranch, stJal, stJalr, stHalt
  } fsmState_e;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra, aluOr,
    aluAnd, aluPassB
  } aluOp_e;

  typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARegA} srcASel_e;
  typedef enum logic [1:0] {srcBRegB, srcBImm, srcBFour} srcBSel_e;
  typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSel_e;

  typedef struct packed {
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;
  } decodedInstr_t;

  typedef struct packed {
    logic zero;   // Operands equal
    logic lt;
    logic ltu;
  } aluFlags_t;

  typedef struct packed {
    logic       pcWrite;
    logic       irWrite;
    logic       regWrite;
    logic       memWrite;
    logic       adrSrc;       // Memory address from result instead of PC
    srcASel_e   srcASel;
    srcBSel_e   srcBSel;
    resultSel_e resultSel;
    aluOp_e     aluOp;
    logic [1:0] accessSize;   // funct3[1:0]
    logic       unsignedLoad; // funct3[2]
  } ctrlSignals_t;

endpackage

/* src/riscv_macros.svh */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// Address of the first fetch after reset
`define RESET_ADDR 32'h0000_0000

// Data and address width
`define XLEN 32

// Architectural registers x0 to x31
`define REG_COUNT 32

// Encoding of addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* test/tbMemory.sv */
`timescale 1ns/100ps

module tbMemory #(
  parameter int Words = 1024
) (
  input  logic        clk,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic [31:0] rdata
);

  logic [31:0] mem [Words];

  // Background pattern unique to each word address
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = 32'h5A00_0000 ^ (i << 2);
    end
  end

  assign rdata = mem[addr[11:2]];   // Combinational read

  always @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (wstrb[lane]) mem[addr[11:2]][8*lane +: 8] <= wdata[8*lane +: 8];
    end
  end

endmodule

/* test/tb_riscvCore.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module tb_riscvCore;

  localparam logic [6:0] OpLoad = 7'b0000011;
  localparam logic [6:0] OpImm = 7'b0010011;
  localparam logic [6:0] OpAuipc = 7'b0010111;
  localparam logic [6:0] OpReg = 7'b0110011;
  localparam logic [6:0] OpLui = 7'b0110111;
  localparam logic [6:0] OpJalr = 7'b1100111;
  localparam logic [31:0] KnownWord = 32'h8F01_7EC3;
  localparam logic [31:0] Marker = 32'h1234_5678;

  logic        clk;
  logic        rstN;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memWstrb;
  logic [31:0] memRdata;
  logic [31:0] progCounter;
  logic        halted;

  logic [15:0] lfsrState = 16'd67;
  logic [31:0] pcw;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] ebreakAddr;
  logic [31:0] expAddr [128];
  logic [31:0] expData [128];
  logic [3:0]  expStrb [128];
  string       expName [128];
  logic        storeBad [128];
  int          nStores = 0;
  int          nInstr = 0;
  int          storeIdx = 0;
  int          reported = 0;
  int          errorCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic        built = 1'b0;
  logic        resetBad = 1'b0;
  logic        haltBad = 1'b0;

  riscvCore u_dut (
    .clk(clk), .rstN(rstN), .memAddr(memAddr), .memWdata(memWdata), .memWstrb(memWstrb),
    .memRdata(memRdata), .progCounter(progCounter), .halted(halted)
  );

  tbMemory uMem (
    .clk(clk), .addr(memAddr), .wdata(memWdata), .wstrb(memWstrb), .rdata(memRdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  task automatic takeBits(input int n, output logic [31:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      v = {v[30:0], fb};
    end
  endtask

  function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // ISA result for OP and OP-IMM by funct3
  function automatic logic [31:0] refAlu(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] refLoad(logic [2:0] f3, logic [1:0] off);
    logic [31:0] s;
    s = KnownWord >> (8 * off);
    case (f3)
      3'd0: return {{24{s[7]}}, s[7:0]};
      3'd4: return {24'b0, s[7:0]};
      3'd1: return {{16{s[15]}}, s[15:0]};
      3'd5: return {16'b0, s[15:0]};
      default: return KnownWord;
    endcase
  endfunction

  function automatic logic refBranch(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    uMem.mem[pcw[11:2]] = word;
    pcw += 4;
  endtask

  task automatic expectStore(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
                             input string name);
    expAddr[nStores] = a;
    expData[nStores] = d;
    expStrb[nStores] = s;
    expName[nStores] = name;
    storeBad[nStores] = 1'b0;
    nStores++;
  endtask

  task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit({hi[19:0], rd, OpLui});
    emit(encI(v[11:0], rd, 3'd0, rd, OpImm));
  endtask

  // SW of rs2 to base register rs1 plus off as a full word store
  task automatic storeReg(input logic [4:0] rs2, input logic [4:0] rs1, input logic [31:0] base,
                          input logic [11:0] off, input logic [31:0] d, input string name);
    emit(encS(off, rs2, rs1, 3'd2));
    expectStore(base + off, d, 4'hF, name);
  endtask

  task automatic buildProgram();
    logic [31:0] v;
    logic [31:0] regs [3];
    logic [31:0] jAddr;
    logic [11:0] slot;
    logic [2:0]  brF3 [6];
    string       aluNames [8];
    aluNames = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};
    brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    pcw = `RESET_ADDR;
    takeBits(32, opA);
    takeBits(32, opB);
    if (opA == opB) opB ^= 32'h1;
    regs = '{32'h0, opA, opB};
    loadConst(1, opA);
    loadConst(2, opB);
    emit(encI(12'h400, 0, 3'd0, 3, OpImm));
    slot = 0;
    for (int f = 0; f < 8; f++) begin                // R-type
      emit({7'h00, 5'd2, 5'd1, 3'(f), 5'd4, OpReg});
      storeReg(4, 3, 32'h400, slot, refAlu(3'(f), 1'b0, opA, opB), aluNames[f]);
      slot += 4;
    end
    emit({7'h20, 5'd2, 5'd1, 3'd0, 5'd4, OpReg});
    storeReg(4, 3, 32'h400, slot, opA - opB, "sub");
    slot += 4;
    emit({7'h20, 5'd2, 5'd1, 3'd5, 5'd4, OpReg});
    storeReg(4, 3, 32'h400, slot, refAlu(3'd5, 1'b1, opA, opB), "sra");
    slot += 4;
    for (int f = 0; f < 8; f++) begin                // OP-IMM with 5 bit shift amounts
      takeBits((f == 1 || f == 5) ? 5 : 12, v);
      emit(encI(v[11:0], 1, 3'(f), 4, OpImm));
      storeReg(4, 3, 32'h400, slot, refAlu(3'(f), 1'b0, opA, {{20{v[11]}}, v[11:0]}),
               {aluNames[f], "i"});
      slot += 4;
    end
    takeBits(5, v);
    emit(encI({7'h20, v[4:0]}, 1, 3'd5, 4, OpImm));
    storeReg(4, 3, 32'h400, slot, refAlu(3'd5, 1'b1, opA, v), "srai");
    slot += 4;
    takeBits(20, v);
    emit({v[19:0], 5'd4, OpLui});
    storeReg(4, 3, 32'h400, slot, {v[19:0], 12'b0}, "lui");
    slot += 4;
    takeBits(20, v);
    jAddr = pcw;
    emit({v[19:0], 5'd4, OpAuipc});
    storeReg(4, 3, 32'h400, slot, jAddr + {v[19:0], 12'b0}, "auipc");
    emit(encI(12'h500, 0, 3'd0, 5, OpImm));         // Sub-word stores
    for (int k = 0; k < 4; k++) begin
      emit(encS(12'(k), 1, 5, 3'd0));
      expectStore(32'h500 + k, {4{opA[7:0]}}, 4'b0001 << k, "sb");
    end
    for (int k = 0; k < 4; k += 2) begin
      emit(encS(12'(k), 1, 5, 3'd1));
      expectStore(32'h500 + k, {2{opA[15:0]}}, (k == 2) ? 4'b1100 : 4'b0011, "sh");
    end
    uMem.mem[32'h600 >> 2] = KnownWord;
    emit(encI(12'h600, 0, 3'd0, 6, OpImm));
    emit(encI(12'h700, 0, 3'd0, 8, OpImm));
    slot = 0;
    for (int k = 0; k < 13; k++) begin                // lb lbu x4, lh lhu x2, lw
      v[2:0] = (k < 4) ? 3'd0 : (k < 8) ? 3'd4 : (k < 10) ? 3'd1 : (k < 12) ? 3'd5 : 3'd2;
      v[4:3] = (k < 8) ? 2'(k) : (k < 12) ? 2'((k % 2) * 2) : 2'd0;
      emit(encI({10'b0, v[4:3]}, 6, v[2:0], 7, OpLoad));
      storeReg(7, 8, 32'h700, slot, refLoad(v[2:0], v[4:3]), "load");
      slot += 4;
    end
    loadConst(9, Marker);
    emit(encI(12'h780, 0, 3'd0, 10, OpImm));
    slot = 0;
    for (int b = 0; b < 6; b++) begin                 // Taken branch skips its marker
      for (int p = 0; p < 3; p++) begin
        v[4:0] = (p == 1) ? 5'd2 : 5'd1;
        v[9:5] = (p == 0) ? 5'd2 : 5'd1;
        emit(encB(13'd8, v[9:5], v[4:0], brF3[b]));
        emit(encS(slot, 9, 10, 3'd2));
        if (!refBranch(brF3[b], regs[v[4:0]], regs[v[9:5]])) begin
          expectStore(32'h780 + slot, Marker, 4'hF, "branch marker");
        end
        slot += 4;
      end
    end
    jAddr = pcw;
    emit(encJ(21'd8, 11));
    emit(encS(slot, 9, 10, 3'd2));                    // Skipped by the jump
    storeReg(11, 10, 32'h780, slot, jAddr + 4, "jal link");
    slot += 4;
    v = pcw + 12;
    emit(encI(v[11:0] + 12'd1, 0, 3'd0, 12, OpImm)); // Odd target for JALR to round down
    jAddr = pcw;
    emit(encI(12'd0, 12, 3'd0, 13, OpJalr));
    emit(encS(slot, 9, 10, 3'd2));
    storeReg(13, 10, 32'h780, slot, jAddr + 4, "jalr link");
    ebreakAddr = pcw;
    emit(32'h0010_0073);
    nInstr = pcw >> 2;
  endtask

  task automatic failValue(input string sig, input logic [31:0] exp, input logic [31:0] act,
                           input int idx);
    $display("** Error: %s expected %h, actual %h (store %0d, %s)", sig, exp, act, idx,
             expName[idx]);
    storeBad[idx] = 1'b1;
    errorCount++;
  endtask

  task automatic reportTest(input string name, input logic bad);
    testsRun++;
    if (bad) testsFailed++;
    $display("%-16s %s", name, bad ? "FAILED" : "ok");
  endtask

  always @(posedge clk) begin
    if (rstN && memWstrb != 4'h0 && storeIdx < nStores) storeIdx <= storeIdx + 1;
  end

  always @(negedge clk) begin
    while (reported < storeIdx) begin
      reportTest(expName[reported], storeBad[reported]);
      reported++;
    end
  end

  assert property (@(posedge clk) $rose(rstN) |->
    (memAddr == `RESET_ADDR && memWstrb == 4'h0 && !halted))
    else begin
      $display("** Error: memAddr %h, memWstrb %h, halted %h after reset, expected %h, 0, 0",
               $sampled(memAddr), $sampled(memWstrb), $sampled(halted), `RESET_ADDR);
      resetBad = 1'b1;
      errorCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN)
    (memWstrb != 4'h0 && storeIdx < nStores) |-> memAddr == expAddr[storeIdx])
    else failValue("memAddr", expAddr[$sampled(storeIdx)], $sampled(memAddr),
                   $sampled(storeIdx));

  assert property (@(posedge clk) disable iff (!rstN)
    (memWstrb != 4'h0 && storeIdx < nStores) |-> memWstrb == expStrb[storeIdx])
    else failValue("memWstrb", expStrb[$sampled(storeIdx)], $sampled(memWstrb),
                   $sampled(storeIdx));

  assert property (@(posedge clk) disable iff (!rstN)
    (memWstrb != 4'h0 && storeIdx < nStores) |-> memWdata == expData[storeIdx])
    else failValue("memWdata", expData[$sampled(storeIdx)], $sampled(memWdata),
                   $sampled(storeIdx));

  assert property (@(posedge clk) disable iff (!rstN)
    (memWstrb != 4'h0) |-> storeIdx < nStores)
    else begin
      $display("Unexpected store to address %h after the last expected one",
               $sampled(memAddr));
      errorCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else begin
      $display("halted dropped after EBREAK");
      haltBad = 1'b1;
      errorCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) halted |-> progCounter == ebreakAddr)
    else begin
      $display("** Error: progCounter expected %h, actual %h", ebreakAddr,
               $sampled(progCounter));
      haltBad = 1'b1;
      errorCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) halted |-> memWstrb == 4'h0)
    else begin
      $display("Store strobe seen while halted");
      haltBad = 1'b1;
      errorCount++;
    end

  // Five cycles per instruction covers the longest class
  initial begin
    wait (built);
    #((nInstr * 5 + 100) * 100);
    $display("Timeout: core did not halt within %0d cycles", nInstr * 5 + 100);
    $display("Test failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    #1;
    buildProgram();
    built = 1'b1;
    repeat (3) @(posedge clk);
    #10 rstN = 1'b1;
    @(posedge clk);
    @(negedge clk);
    reportTest("reset", resetBad);
    wait (halted);
    repeat (10) @(posedge clk);
    @(negedge clk);
    reportTest("halt", haltBad);
    if (storeIdx != nStores) begin
      $display("Only %0d of %0d expected stores were seen", storeIdx, nStores);
      errorCount++;
    end
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
